//--- files.f
source/ptw_pkg.sv
source/ptw_pte_check.sv
source/ptw_walk_ctrl.sv
source/ptw_top.sv
test/tb_ptw_mem.sv
test/tb_ptw.sv

//--- run.sh
#!/bin/sh
# Build and run the walker testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_ptw -f files.f \
    --Mdir obj_dir -o sim_ptw > build.log 2>&1 \
    && ./obj_dir/sim_ptw > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "Finished with no errors" sim.log && exit 0 || exit 1

//--- source/ptw_pkg.sv
/*
 * Sv39 page table walker shared definitions
 * Address, page number, context and cause widths with their vector types
 * Page table entry layout, walk levels and the entry check verdict
 * Fault cause codes and the translation cache update record
 */

package ptw_pkg;

    // Sv39 widths
    localparam int unsigned IOVA_W  = 39;
    localparam int unsigned PPN_W   = 44;
    localparam int unsigned PADDR_W = 56;
    localparam int unsigned PSCID_W = 20;
    localparam int unsigned CAUSE_W = 12;
    // Three 9-bit VPN segments
    localparam int unsigned VPN_W   = 27;

    typedef logic [IOVA_W-1:0]  iova_t;
    typedef logic [PPN_W-1:0]   ppn_t;
    typedef logic [PADDR_W-1:0] paddr_t;
    typedef logic [PSCID_W-1:0] pscid_t;
    typedef logic [CAUSE_W-1:0] cause_t;

    // One 64-bit page table entry, MSB first
    typedef struct packed {
        logic [9:0] reserved;
        ppn_t       ppn;
        logic [1:0] rsw;
        logic       d;
        logic       a;
        logic       g;
        logic       u;
        logic       x;
        logic       w;
        logic       r;
        logic       v;
    } pte_t;

    // Walk levels, LVL1 is the root table (1G granule)
    typedef enum logic [1:0] {
        LVL1,
        LVL2,
        LVL3
    } ptw_level_e;

    // Verdict on one entry
    typedef struct packed {
        logic is_leaf;
        logic fault;
        logic global;
    } pte_result_t;

    // Fault causes reported with error_o
    localparam cause_t CAUSE_LOAD_PAGE_FAULT    = 12'd13;
    localparam cause_t CAUSE_STORE_PAGE_FAULT   = 12'd15;
    // Bus error on an entry read
    localparam cause_t CAUSE_PT_DATA_CORRUPTION = 12'd274;

    // Translation cache update contents
    typedef struct packed {
        logic [VPN_W-1:0] vpn;
        pscid_t           pscid;
        logic             is_2m;
        logic             is_1g;
        // Leaf entry, g holds the global bit gathered over all levels
        pte_t             content;
    } iotlb_update_t;

endpackage

//--- source/ptw_pte_check.sv
/*
 * Page table entry checker
 * Classifies a returned entry as leaf or pointer and flags page faults
 * Builds the pointer to the next level table entry
 */

module ptw_pte_check import ptw_pkg::*; (
    input  pte_t        pte_i,
    input  ptw_level_e  level_i,
    input  logic        is_store_i,
    input  iova_t       vpn_i,
    output pte_result_t result_o,
    output paddr_t      next_ptr_o
);

    logic is_leaf;
    logic invalid;
    logic rsvd_set;
    logic misaligned;
    logic leaf_perm_fault;
    logic ptr_bits_set;
    logic underflow;
    logic leaf_fault;
    logic ptr_fault;

    // Readable or executable entries end the walk
    assign is_leaf = pte_i.r | pte_i.x;

    // Not valid, or write-only which is a reserved encoding
    assign invalid = ~pte_i.v | (pte_i.w & ~pte_i.r);

    // Upper ten bits must be zero without the matching extensions
    assign rsvd_set = |pte_i.reserved;

    // Superpage ppn must be aligned to its own size
    always_comb begin
        misaligned = 1'b0;
        case (level_i)
            // 1G page, low two ppn segments zero
            LVL1:    misaligned = |pte_i.ppn[17:0];
            // 2M page, low ppn segment zero
            LVL2:    misaligned = |pte_i.ppn[8:0];
            default: misaligned = 1'b0;
        endcase
    end

    // A clear, no read permission, or store to a clean page
    assign leaf_perm_fault = ~pte_i.a | ~pte_i.r | (is_store_i & ~pte_i.d);

    // D, A and U are reserved on pointer entries
    assign ptr_bits_set = pte_i.a | pte_i.d | pte_i.u;

    // No table below level 3
    assign underflow = (level_i == LVL3);

    assign leaf_fault = misaligned | leaf_perm_fault;
    assign ptr_fault  = ptr_bits_set | underflow;

    always_comb begin
        result_o.is_leaf = is_leaf;
        result_o.global  = pte_i.g;
        // Invalid and reserved-bit faults apply to both entry kinds
        result_o.fault   = invalid | rsvd_set | (is_leaf ? leaf_fault : ptr_fault);
    end

    // Next entry address, ppn joined with the next VPN segment, 8-byte entries
    always_comb begin
        case (level_i)
            LVL1:    next_ptr_o = {pte_i.ppn, vpn_i[29:21], 3'b000};
            // At level 3 a pointer faults, so this value is never used
            default: next_ptr_o = {pte_i.ppn, vpn_i[20:12], 3'b000};
        endcase
    end

endmodule

//--- source/ptw_top.sv
/*
 * Sv39 hardware page table walker top level
 * Walk controller and entry checker joined together
 */

module ptw_top import ptw_pkg::*; (
    input  logic          clk_i,
    input  logic          rst_ni,

    // Miss request from the translation cache
    input  logic          miss_i,
    input  iova_t         iova_i,
    input  pscid_t        pscid_i,
    input  ppn_t          root_ppn_i,
    input  logic          en_i,
    input  logic          is_store_i,

    // Memory read port
    output logic          rd_req_o,
    output paddr_t        rd_addr_o,
    input  logic          rd_gnt_i,
    input  logic          rd_valid_i,
    input  pte_t          rd_data_i,
    input  logic          rd_err_i,

    // Results
    output logic          update_o,
    output iotlb_update_t update_data_o,
    output logic          error_o,
    output cause_t        cause_o,
    output logic          bare_o,
    output logic          busy_o
);

    // Controller to checker
    ptw_level_e  level;
    iova_t       walk_iova;
    // Checker back to controller
    pte_result_t result;
    paddr_t      next_ptr;

    ptw_walk_ctrl i_walk_ctrl (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .miss_i        (miss_i),
        .en_i          (en_i),
        .iova_i        (iova_i),
        .pscid_i       (pscid_i),
        .root_ppn_i    (root_ppn_i),
        .is_store_i    (is_store_i),
        .rd_req_o      (rd_req_o),
        .rd_addr_o     (rd_addr_o),
        .rd_gnt_i      (rd_gnt_i),
        .rd_valid_i    (rd_valid_i),
        .rd_err_i      (rd_err_i),
        .rd_data_i     (rd_data_i),
        .level_o       (level),
        .iova_o        (walk_iova),
        .result_i      (result),
        .next_ptr_i    (next_ptr),
        .update_o      (update_o),
        .update_data_o (update_data_o),
        .error_o       (error_o),
        .cause_o       (cause_o),
        .bare_o        (bare_o),
        .busy_o        (busy_o)
    );

    // Read data goes straight to the checker
    ptw_pte_check i_pte_check (
        .pte_i      (rd_data_i),
        .level_i    (level),
        .is_store_i (is_store_i),
        .vpn_i      (walk_iova),
        .result_o   (result),
        .next_ptr_o (next_ptr)
    );

endmodule

//--- source/ptw_walk_ctrl.sv
/*
 * Page table walk controller
 * FSM stepping through the Sv39 levels on a cache miss
 * Memory read strobes, walk registers, cache update and fault reporting
 */

module ptw_walk_ctrl import ptw_pkg::*; (
    input  logic          clk_i,
    input  logic          rst_ni,

    // Miss request
    input  logic          miss_i,
    input  logic          en_i,
    input  iova_t         iova_i,
    input  pscid_t        pscid_i,
    input  ppn_t          root_ppn_i,
    input  logic          is_store_i,

    // Memory read port
    output logic          rd_req_o,
    output paddr_t        rd_addr_o,
    input  logic          rd_gnt_i,
    input  logic          rd_valid_i,
    input  logic          rd_err_i,
    input  pte_t          rd_data_i,

    // Entry checker
    output ptw_level_e    level_o,
    output iova_t         iova_o,
    input  pte_result_t   result_i,
    input  paddr_t        next_ptr_i,

    // Results
    output logic          update_o,
    output iotlb_update_t update_data_o,
    output logic          error_o,
    output cause_t        cause_o,
    output logic          bare_o,
    output logic          busy_o
);

    typedef enum logic [1:0] {
        IDLE,
        MEM_ACCESS,
        PTE_LOOKUP,
        PROPAGATE_ERROR
    } state_e;

    state_e     state_q, state_n;
    ptw_level_e level_q, level_n;
    logic       global_q, global_n;

    // Walk payload, captured on the miss
    iova_t      iova_q, iova_n;
    pscid_t     pscid_q, pscid_n;
    paddr_t     ptr_q, ptr_n;
    cause_t     cause_q, cause_n;

    // Checker works on the captured address and current level
    assign level_o = level_q;
    assign iova_o  = iova_q;

    // Request address stays on the pointer register while waiting for grant
    assign rd_addr_o = ptr_q;

    assign busy_o = (state_q != IDLE);

    always_comb begin
        state_n  = state_q;
        level_n  = level_q;
        global_n = global_q;
        iova_n   = iova_q;
        pscid_n  = pscid_q;
        ptr_n    = ptr_q;
        cause_n  = cause_q;

        rd_req_o = 1'b0;
        update_o = 1'b0;
        error_o  = 1'b0;
        cause_o  = '0;
        bare_o   = 1'b0;

        unique case (state_q)
            IDLE: begin
                if (miss_i) begin
                    if (en_i) begin
                        // Start at the root table
                        level_n  = LVL1;
                        global_n = 1'b0;
                        iova_n   = iova_i;
                        pscid_n  = pscid_i;
                        ptr_n    = {root_ppn_i, iova_i[38:30], 3'b000};
                        state_n  = MEM_ACCESS;
                    end else begin
                        // Translation off, answer at once without a walk
                        bare_o = 1'b1;
                    end
                end
            end

            MEM_ACCESS: begin
                rd_req_o = 1'b1;
                if (rd_gnt_i) begin
                    state_n = PTE_LOOKUP;
                end
            end

            PTE_LOOKUP: begin
                // Data is taken in the single valid cycle
                if (rd_valid_i) begin
                    if (rd_err_i) begin
                        // Bus error wins over anything the data might say
                        cause_n = CAUSE_PT_DATA_CORRUPTION;
                        state_n = PROPAGATE_ERROR;
                    end else if (result_i.fault) begin
                        cause_n = is_store_i ? CAUSE_STORE_PAGE_FAULT : CAUSE_LOAD_PAGE_FAULT;
                        state_n = PROPAGATE_ERROR;
                    end else if (result_i.is_leaf) begin
                        update_o = 1'b1;
                        state_n  = IDLE;
                    end else begin
                        // Pointer entry, descend one level
                        global_n = global_q | result_i.global;
                        ptr_n    = next_ptr_i;
                        level_n  = (level_q == LVL1) ? LVL2 : LVL3;
                        state_n  = MEM_ACCESS;
                    end
                end
            end

            PROPAGATE_ERROR: begin
                error_o = 1'b1;
                cause_o = cause_q;
                state_n = IDLE;
            end

            default: begin
                state_n = IDLE;
            end
        endcase
    end

    // Update record, only meaningful while update_o is high
    always_comb begin
        update_data_o.vpn       = iova_q[38:12];
        update_data_o.pscid     = pscid_q;
        // Page size follows the level where the leaf was found
        update_data_o.is_2m     = (level_q == LVL2);
        update_data_o.is_1g     = (level_q == LVL1);
        update_data_o.content   = rd_data_i;
        // Global if any level on the path had g set
        update_data_o.content.g = global_q | result_i.global;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q  <= IDLE;
            level_q  <= LVL1;
            global_q <= 1'b0;
        end else begin
            state_q  <= state_n;
            level_q  <= level_n;
            global_q <= global_n;
        end
    end

    always_ff @(posedge clk_i) begin
        iova_q  <= iova_n;
        pscid_q <= pscid_n;
        ptr_q   <= ptr_n;
        cause_q <= cause_n;
    end

endmodule

//--- test/tb_ptw.sv
/*
 * Testbench for the Sv39 page table walker
 * Builds page tables, runs walks with random latencies and IOVAs
 * Assertions check updates, faults, read addresses and the bare pulse
 */

module tb_ptw import ptw_pkg::*; ();

    localparam int NUM_TESTS = 12;
    // Tests times levels times cycles per level, plus reset and gaps
    localparam int CYCLE_LIMIT = NUM_TESTS * 3 * 10 + 200;
    localparam ppn_t ROOT_PPN = 44'h100;
    // Flag bytes d a g u x w r v
    localparam logic [7:0] F_PTR   = 8'b0000_0001;
    localparam logic [7:0] F_PTR_G = 8'b0010_0001;
    localparam logic [7:0] F_PTR_A = 8'b0100_0001;
    localparam logic [7:0] F_LEAF  = 8'b1100_0111;
    localparam logic [7:0] F_CLEAN = 8'b0100_0111;

    logic clk_i = 1'b0;
    logic rst_ni, miss_i, en_i, is_store_i;
    iova_t iova_i;
    pscid_t pscid_i;
    ppn_t root_ppn_i;
    logic rd_req_o, rd_gnt_i, rd_valid_i, rd_err_i;
    paddr_t rd_addr_o;
    pte_t rd_data_i;
    logic update_o, error_o, bare_o, busy_o;
    iotlb_update_t update_data_o;
    cause_t cause_o;
    logic [1:0] gnt_lat, val_lat;
    logic err_inj;

    logic [31:0] lfsr_q = 32'h765a_0fd8;
    int errors = 0;
    int failed_tests = 0;
    int cycles = 0;
    int ends = 0;
    int n_upd, n_err, n_bare;
    int exp_kind;
    iotlb_update_t exp_upd;
    cause_t exp_cause;
    paddr_t exp_addr [$];

    always #2 clk_i = ~clk_i;

    ptw_top i_dut (.*);

    tb_ptw_mem i_mem (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .rd_req_i   (rd_req_o),
        .rd_addr_i  (rd_addr_o),
        .gnt_lat_i  (gnt_lat),
        .val_lat_i  (val_lat),
        .err_inj_i  (err_inj),
        .rd_gnt_o   (rd_gnt_i),
        .rd_valid_o (rd_valid_i),
        .rd_data_o  (rd_data_i),
        .rd_err_o   (rd_err_i)
    );

    task automatic flag_failure(input string msg);
        errors++;
        $display("error: %s", msg);
    endtask

    task automatic report_mismatch(input string sig, input logic [127:0] got,
                                   input logic [127:0] exp);
        errors++;
        $display("mismatch %s got %h expected %h", sig, got, exp);
    endtask

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
    function automatic logic [63:0] draw_bits(input int n);
        logic fb;
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            v = {v[62:0], fb};
        end
        return v;
    endfunction

    function automatic pte_t make_pte(input ppn_t ppn, input logic [7:0] flags);
        pte_t p;
        p = '0;
        p.ppn = ppn;
        {p.d, p.a, p.g, p.u, p.x, p.w, p.r, p.v} = flags;
        return p;
    endfunction

    // Scoreboard checks on every sampled edge
    always @(posedge clk_i) begin
        if (rst_ni) begin
            if (update_o) begin
                n_upd++;
                ends++;
                assert (exp_kind == 0) else flag_failure("update_o on a walk that must fault");
                assert (update_data_o == exp_upd) else
                    report_mismatch("update_data_o", update_data_o, exp_upd);
            end
            if (error_o) begin
                n_err++;
                ends++;
                assert (exp_kind == 1) else flag_failure("error_o on a walk that must succeed");
                assert (cause_o == exp_cause) else report_mismatch("cause_o", cause_o, exp_cause);
            end
            if (bare_o) begin
                n_bare++;
                ends++;
                assert (exp_kind == 2) else flag_failure("bare_o with translation enabled");
            end
            if (rd_req_o && rd_gnt_i) begin
                if (exp_addr.size() == 0) begin
                    flag_failure("read issued beyond the expected walk");
                end else begin
                    assert (rd_addr_o == exp_addr[0]) else
                        report_mismatch("rd_addr_o", rd_addr_o, exp_addr[0]);
                    void'(exp_addr.pop_front());
                end
            end
        end
    end

    // Request holds with a stable address until granted
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        rd_req_o && !rd_gnt_i |=> rd_req_o && $stable(rd_addr_o))
        else flag_failure("read request dropped or address moved before grant");

    // Request rises one cycle after an accepted miss
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        miss_i && en_i && !busy_o |=> rd_req_o && busy_o)
        else flag_failure("walk did not start one cycle after the miss");

    // Bare pulse comes with the miss and starts no walk
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        bare_o |-> miss_i ##1 (!rd_req_o && !busy_o))
        else flag_failure("bare translation was late or started a walk");

    // Update in the valid cycle, walker idle right after
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        update_o |-> (busy_o && rd_valid_i) ##1 !busy_o)
        else flag_failure("update pulse out of place in the walk");

    // Error one cycle after the valid data, then idle
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        error_o |-> (busy_o && $past(rd_valid_i)) ##1 !busy_o)
        else flag_failure("error pulse out of place in the walk");

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles", cycles);
            $display("Finished with errors");
            $finish;
        end
    end

    // One miss, a second ignored miss while busy, then wait for the end pulse
    task automatic run_walk(input int id, input string name, input logic st, input int n,
                            input pte_t p1, input pte_t p2, input pte_t p3,
                            input int kind, input logic inj);
        logic [63:0] v;
        iova_t va;
        pte_t leaf;
        paddr_t a1, a2, a3;
        int start_ends, start_err, waited;
        start_err = errors;
        v = draw_bits(39);
        va = v[38:0];
        v = draw_bits(2);
        gnt_lat <= v[1:0];
        v = draw_bits(2);
        val_lat <= v[1:0];
        err_inj <= inj;
        i_mem.mem.delete();
        exp_addr.delete();
        a1 = {ROOT_PPN, va[38:30], 3'b000};
        a2 = {p1.ppn, va[29:21], 3'b000};
        a3 = {p2.ppn, va[20:12], 3'b000};
        if (n > 0) begin
            i_mem.mem[a1] = p1;
            exp_addr.push_back(a1);
        end
        if (n > 1) begin
            i_mem.mem[a2] = p2;
            exp_addr.push_back(a2);
        end
        if (n > 2) begin
            i_mem.mem[a3] = p3;
            exp_addr.push_back(a3);
        end
        leaf = (n == 1) ? p1 : (n == 2) ? p2 : p3;
        exp_upd.vpn = va[38:12];
        exp_upd.pscid = 20'(id * 4099);
        exp_upd.is_1g = (n == 1);
        exp_upd.is_2m = (n == 2);
        exp_upd.content = leaf;
        exp_upd.content.g = p1.g | (n > 1 && p2.g) | (n > 2 && p3.g);
        exp_cause = inj ? CAUSE_PT_DATA_CORRUPTION :
                    st ? CAUSE_STORE_PAGE_FAULT : CAUSE_LOAD_PAGE_FAULT;
        exp_kind = kind;
        n_upd = 0;
        n_err = 0;
        n_bare = 0;
        start_ends = ends;
        @(posedge clk_i);
        en_i <= (kind != 2);
        is_store_i <= st;
        iova_i <= va;
        pscid_i <= exp_upd.pscid;
        miss_i <= 1'b1;
        @(posedge clk_i);
        miss_i <= 1'b0;
        if (kind != 2) begin
            @(posedge clk_i);
            iova_i <= va ^ 39'h40000000;
            pscid_i <= ~exp_upd.pscid;
            miss_i <= 1'b1;
            @(posedge clk_i);
            miss_i <= 1'b0;
        end
        waited = 0;
        while (ends == start_ends && waited < 60) begin
            @(posedge clk_i);
            waited++;
        end
        if (ends == start_ends) flag_failure("walk never ended");
        repeat (3) @(posedge clk_i);
        assert (n_upd == (kind == 0)) else report_mismatch("update count", n_upd, kind == 0);
        assert (n_err == (kind == 1)) else report_mismatch("error count", n_err, kind == 1);
        assert (n_bare == (kind == 2)) else report_mismatch("bare count", n_bare, kind == 2);
        assert (exp_addr.size() == 0) else flag_failure("walk skipped a read");
        assert (!busy_o) else flag_failure("walker still busy after the end pulse");
        if (errors != start_err) failed_tests++;
        $display("test %0d %s: %s", id, name, (errors == start_err) ? "ok" : "failed");
    endtask

    initial begin
        rst_ni = 1'b0;
        miss_i = 1'b0;
        en_i = 1'b1;
        is_store_i = 1'b0;
        iova_i = '0;
        pscid_i = '0;
        root_ppn_i = ROOT_PPN;
        gnt_lat = '0;
        val_lat = '0;
        err_inj = 1'b0;
        exp_kind = 0;
        exp_upd = '0;
        exp_cause = '0;
        repeat (5) @(posedge clk_i);
        rst_ni <= 1'b1;
        run_walk(1, "4K load", 0, 3, make_pte(44'h200, F_PTR), make_pte(44'h300, F_PTR_G),
                 make_pte(44'h12345, F_LEAF), 0, 0);
        run_walk(2, "4K store", 1, 3, make_pte(44'h210, F_PTR), make_pte(44'h310, F_PTR),
                 make_pte(44'h54321, F_LEAF), 0, 0);
        run_walk(3, "2M leaf", 0, 2, make_pte(44'h220, F_PTR_G), make_pte(44'h1200, F_LEAF),
                 '0, 0, 0);
        run_walk(4, "1G leaf", 1, 1, make_pte(44'h40000, F_LEAF), '0, '0, 0, 0);
        run_walk(5, "misaligned 1G", 0, 1, make_pte(44'h40001, F_LEAF), '0, '0, 1, 0);
        run_walk(6, "invalid entry", 1, 2, make_pte(44'h230, F_PTR), '0, '0, 1, 0);
        run_walk(7, "reserved bits", 0, 3, make_pte(44'h240, F_PTR), make_pte(44'h340, F_PTR),
                 make_pte(44'h777, F_LEAF) | 64'h0040_0000_0000_0000, 1, 0);
        run_walk(8, "store to clean page", 1, 3, make_pte(44'h250, F_PTR),
                 make_pte(44'h350, F_PTR), make_pte(44'h888, F_CLEAN), 1, 0);
        run_walk(9, "pointer with A set", 0, 1, make_pte(44'h260, F_PTR_A), '0, '0, 1, 0);
        run_walk(10, "pointer at level 3", 1, 3, make_pte(44'h270, F_PTR),
                 make_pte(44'h370, F_PTR), make_pte(44'h470, F_PTR), 1, 0);
        run_walk(11, "read error", 0, 1, make_pte(44'h280, F_PTR), '0, '0, 1, 1);
        run_walk(12, "bare translation", 0, 0, '0, '0, '0, 2, 0);
        $display("tests %0d failed %0d errors %0d", NUM_TESTS, failed_tests, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- test/tb_ptw_mem.sv
/*
 * Page table memory model for the walker testbench
 * Holds entries in a sparse array written by the testbench
 * Grants and answers reads after programmable latencies, optional read error
 */

module tb_ptw_mem import ptw_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_ni,
    input  logic       rd_req_i,
    input  paddr_t     rd_addr_i,
    input  logic [1:0] gnt_lat_i,
    input  logic [1:0] val_lat_i,
    input  logic       err_inj_i,
    output logic       rd_gnt_o,
    output logic       rd_valid_o,
    output pte_t       rd_data_o,
    output logic       rd_err_o
);

    // Sparse entry storage, missing entries read as zero
    pte_t mem [paddr_t];

    logic       waiting_val;
    logic [1:0] cnt;
    paddr_t     addr_q;

    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_gnt_o    <= 1'b0;
            rd_valid_o  <= 1'b0;
            rd_data_o   <= '0;
            rd_err_o    <= 1'b0;
            waiting_val <= 1'b0;
            cnt         <= '0;
            addr_q      <= '0;
        end else begin
            // Strobes last one cycle
            rd_gnt_o   <= 1'b0;
            rd_valid_o <= 1'b0;
            rd_err_o   <= 1'b0;
            if (!waiting_val) begin
                if (!rd_req_i) begin
                    cnt <= gnt_lat_i;
                end else if (cnt == 0) begin
                    rd_gnt_o    <= 1'b1;
                    addr_q      <= rd_addr_i;
                    waiting_val <= 1'b1;
                    cnt         <= val_lat_i;
                end else begin
                    cnt <= cnt - 1'b1;
                end
            end else if (cnt == 0) begin
                rd_valid_o  <= 1'b1;
                rd_err_o    <= err_inj_i;
                rd_data_o   <= mem.exists(addr_q) ? mem[addr_q] : '0;
                waiting_val <= 1'b0;
                cnt         <= gnt_lat_i;
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

endmodule
